/* filelist.f */
+incdir+hw
hw/pcs_pkg.sv
hw/pcs_encoder.sv
hw/pcs_scrambler.sv
hw/am_lane_tx.sv
hw/am_tx.sv
hw/pcs_tx_top.sv
tests/pcs_tx_tb.sv

/* hw/am_lane_tx.sv */
// Lane alignment marker insertion
`timescale 1ns/100ps
`include "pcs_settings.svh"

module am_lane_tx #(
	parameter logic [`PCS_DATA_W-1:0] LANE_ENC = `PCS_AM_LANE0
) (
	input  logic                   clk,
	input  logic                   nreset,
	input  logic                   valid_i,
	input  logic                   marker_v_i,
	input  pcs_pkg::block_head_t   head_i,
	input  logic [`PCS_DATA_W-1:0] data_i,
	output pcs_pkg::block_head_t   head_o,
	output logic [`PCS_DATA_W-1:0] data_o
);

	// full block width, header in the two low bits
	localparam int BLK_W = `PCS_HEAD_W + `PCS_DATA_W;

	logic [7:0]             bip_q;
	logic [7:0]             bip_next;
	logic [`PCS_DATA_W-1:0] marker_data;
	pcs_pkg::block_head_t   head_sel;
	logic [`PCS_DATA_W-1:0] data_sel;
	pcs_pkg::block_head_t   head_q;
	logic [`PCS_DATA_W-1:0] data_q;

	// bit k is the parity of every block bit whose index is k mod 8
	function automatic logic [7:0] bip_fold(input logic [BLK_W-1:0] blk);
		logic [7:0] p;
		p = '0;
		for (int i = 0; i < BLK_W; i++) begin
			p[i % 8] = p[i % 8] ^ blk[i];
		end
		return p;
	endfunction

	// fixed lane bytes with BIP3 in byte 3 and its inverse BIP7 in byte 7
	always_comb begin
		marker_data        = LANE_ENC;
		marker_data[31:24] = bip_q;
		marker_data[63:56] = ~bip_q;
	end

	// the marker takes the place of the incoming block
	// upstream holds that block for the next beat
	assign head_sel = marker_v_i ? pcs_pkg::HEAD_CTRL : head_i;
	assign data_sel = marker_v_i ? marker_data : data_i;

	// a marker restarts the parity from its own bits
	// any other block folds into the running value
	assign bip_next = marker_v_i ? bip_fold({data_sel, head_sel})
		: bip_q ^ bip_fold({data_sel, head_sel});

	// output register, advances on every beat the gearbox accepts
	always_ff @(posedge clk) begin
		if (nreset) begin
			head_q <= '0;
			data_q <= '0;
			bip_q  <= '0;
		end else if (valid_i) begin
			head_q <= head_sel;
			data_q <= data_sel;
			bip_q  <= bip_next;
		end
	end

	assign head_o = head_q;
	assign data_o = data_q;

endmodule

/* hw/am_tx.sv */
// Alignment marker insertion
`timescale 1ns/100ps
`include "pcs_settings.svh"

module am_tx (
	input  logic                                clk,
	input  logic                                nreset,
	// gearbox accepts a block this cycle
	input  logic                                valid_i,
	input  logic [`PCS_LANE_N*`PCS_HEAD_W-1:0]  head_i,
	input  logic [`PCS_LANE_N*`PCS_DATA_W-1:0]  data_i,
	output logic [`PCS_LANE_N*`PCS_HEAD_W-1:0]  head_o,
	output logic [`PCS_LANE_N*`PCS_DATA_W-1:0]  data_o,
	// marker beat, doubles as the upstream stall
	output logic                                marker_v_o
);

	localparam int GAP_W = `PCS_AM_GAP_W;

	// marker bytes of all lanes, lane 0 in the low word
	localparam logic [`PCS_LANE_N*`PCS_DATA_W-1:0] MARKER_ALL = {
		`PCS_AM_LANE3,
		`PCS_AM_LANE2,
		`PCS_AM_LANE1,
		`PCS_AM_LANE0
	};

	logic [GAP_W-1:0] gap_q;
	logic [GAP_W-1:0] gap_next;
	logic             marker_next;
	logic             marker_q;

	// the counter wraps on its own width, one marker per 2^14 beats
	assign gap_next = gap_q + GAP_W'(1);

	// all ones now means a marker goes out on the next beat
	assign marker_next = &gap_q;

	// starting at 1 puts the first marker on beat 16383
	always_ff @(posedge clk) begin
		if (nreset) begin
			gap_q    <= GAP_W'(1);
			marker_q <= 1'b0;
		end else if (valid_i) begin
			gap_q    <= gap_next;
			marker_q <= marker_next;
		end
	end

	// one inserter per lane, all driven by the same marker flag
	for (genvar i = 0; i < `PCS_LANE_N; i++) begin : gen_lane
		pcs_pkg::block_head_t   head_lane;
		logic [`PCS_DATA_W-1:0] data_lane;

		am_lane_tx #(
			.LANE_ENC(MARKER_ALL[i*`PCS_DATA_W +: `PCS_DATA_W])
		) m_am_lane (
			.clk       (clk),
			.nreset    (nreset),
			.valid_i   (valid_i),
			.marker_v_i(marker_q),
			.head_i    (head_i[i*`PCS_HEAD_W +: `PCS_HEAD_W]),
			.data_i    (data_i[i*`PCS_DATA_W +: `PCS_DATA_W]),
			.head_o    (head_lane),
			.data_o    (data_lane)
		);

		assign head_o[i*`PCS_HEAD_W +: `PCS_HEAD_W] = head_lane;
		assign data_o[i*`PCS_DATA_W +: `PCS_DATA_W] = data_lane;
	end

	assign marker_v_o = marker_q;

endmodule

/* hw/pcs_encoder.sv */
// Lane 64b/66b encoder
`timescale 1ns/100ps
`include "pcs_settings.svh"

module pcs_encoder (
	input  logic                          clk,
	input  logic                          nreset,
	input  logic                          advance_i,
	input  logic [`PCS_DATA_W-1:0]        xgmii_data_i,
	input  logic [`PCS_CTRL_W-1:0]        xgmii_ctrl_i,
	output pcs_pkg::block_head_t          head_o,
	output pcs_pkg::block_payload_u       payload_o
);

	// XGMII idle character
	localparam logic [7:0] XGMII_IDLE = 8'h07;

	logic                    is_data;
	logic                    is_idle;
	logic                    bytes_idle;
	pcs_pkg::block_head_t    head_next;
	pcs_pkg::block_payload_u payload_next;
	pcs_pkg::block_head_t    head_q;
	pcs_pkg::block_payload_u payload_q;

	// a word with no control bit set is plain data
	assign is_data = ~|xgmii_ctrl_i;

	// every byte must hold the idle character
	always_comb begin
		bytes_idle = 1'b1;
		for (int i = 0; i < `PCS_CTRL_W; i++) begin
			if (xgmii_data_i[i*8 +: 8] != XGMII_IDLE) begin
				bytes_idle = 1'b0;
			end
		end
	end

	// all lanes flagged as control and all of them idle
	assign is_idle = (&xgmii_ctrl_i) & bytes_idle;

	// pick the block layout, data view or control view of the payload
	always_comb begin
		if (is_data) begin
			head_next         = pcs_pkg::HEAD_DATA;
			payload_next.data = xgmii_data_i;
		end else begin
			head_next                = pcs_pkg::HEAD_CTRL;
			payload_next.ctrl.btype  = pcs_pkg::BLOCK_TYPE_CTRL;
			// anything that is not a clean idle word is reported as an error block
			for (int i = 0; i < 8; i++) begin
				payload_next.ctrl.code[i] = is_idle ? pcs_pkg::CTRL_IDLE
					: pcs_pkg::CTRL_ERROR;
			end
		end
	end

	// block register, only moves when the word is consumed
	always_ff @(posedge clk) begin
		if (nreset) begin
			head_q    <= '0;
			payload_q <= '0;
		end else if (advance_i) begin
			head_q    <= head_next;
			payload_q <= payload_next;
		end
	end

	assign head_o    = head_q;
	assign payload_o = payload_q;

endmodule

/* hw/pcs_pkg.sv */
// PCS block types
`include "pcs_settings.svh"

package pcs_pkg;

	// sync header of a 66-bit block
	typedef logic [`PCS_HEAD_W-1:0] block_head_t;

	// header code of a block carrying eight data bytes
	localparam block_head_t HEAD_DATA = 2'b01;
	// header code of a block starting with a block type field
	localparam block_head_t HEAD_CTRL = 2'b10;

	// only the control-only block type is produced here
	typedef enum logic [7:0] {
		BLOCK_TYPE_CTRL = 8'h1e
	} block_type_e;

	// 7-bit control codes carried in a control-only block
	typedef enum logic [6:0] {
		CTRL_IDLE  = 7'h00,
		CTRL_ERROR = 7'h1e
	} ctrl_code_e;

	// control view of a payload
	// the block type sits in the low byte so that it goes out first on the line
	typedef struct packed {
		ctrl_code_e [7:0] code;
		block_type_e      btype;
	} ctrl_block_t;

	// one payload decoded either as raw data bytes or as a control block
	typedef union packed {
		logic [`PCS_DATA_W/8-1:0][7:0] data;
		ctrl_block_t                   ctrl;
	} block_payload_u;

endpackage

/* hw/pcs_scrambler.sv */
// Lane payload scrambler
`timescale 1ns/100ps
`include "pcs_settings.svh"

module pcs_scrambler (
	input  logic                   clk,
	input  logic                   nreset,
	input  logic                   advance_i,
	input  logic [`PCS_DATA_W-1:0] payload_i,
	output logic [`PCS_DATA_W-1:0] payload_o
);

	// polynomial 1 + x^39 + x^58
	localparam int SCR_W = 58;
	localparam int TAP_A = 38;
	localparam int TAP_B = 57;

	logic [SCR_W-1:0]       state_q;
	logic [SCR_W-1:0]       state_next;
	logic [`PCS_DATA_W-1:0] scr;

	// self-synchronous scrambler, bit 0 goes first
	// the newest scrambled bit enters the state at position 0, so
	// bit 38 is the output from 39 bits back and bit 57 from 58 back
	always_comb begin
		state_next = state_q;
		for (int i = 0; i < `PCS_DATA_W; i++) begin
			scr[i]     = payload_i[i] ^ state_next[TAP_A] ^ state_next[TAP_B];
			state_next = {state_next[SCR_W-2:0], scr[i]};
		end
	end

	// state moves only with consumed words
	// marker beats hold it, the marker itself is never scrambled
	always_ff @(posedge clk) begin
		if (nreset) begin
			state_q <= '1;
		end else if (advance_i) begin
			state_q <= state_next;
		end
	end

	// output is combinational, the marker inserter registers it
	assign payload_o = scr;

endmodule

/* hw/pcs_settings.svh */
// PCS transmit parameters
`ifndef PCS_SETTINGS_SVH
`define PCS_SETTINGS_SVH

// number of physical lanes
`define PCS_LANE_N 4

// sync header and payload widths of one 66-bit block
`define PCS_HEAD_W 2
`define PCS_DATA_W 64

// XGMII control bits per lane, one per data byte
`define PCS_CTRL_W 8

// gap counter width, a marker goes out once every 2^14 beats
`define PCS_AM_GAP_W 14

// fixed marker bytes per lane, byte 0 in the low bits
// bytes 3 and 7 are placeholders that the BIP3 and BIP7 values overwrite
`define PCS_AM_LANE0 64'h00_b8_89_6f_00_47_76_90
`define PCS_AM_LANE1 64'h00_19_3b_0f_00_e6_c4_f0
`define PCS_AM_LANE2 64'h00_64_9a_3a_00_9b_65_c5
`define PCS_AM_LANE3 64'h00_c2_86_5d_00_3d_79_a2

`endif

/* hw/pcs_tx_top.sv */
// PCS transmit top
`timescale 1ns/100ps
`include "pcs_settings.svh"

module pcs_tx_top (
	input  logic                                clk,
	input  logic                                nreset,
	// one XGMII word per lane is offered while this is high
	input  logic                                tx_valid_i,
	input  logic [`PCS_LANE_N*`PCS_DATA_W-1:0]  xgmii_data_i,
	input  logic [`PCS_LANE_N*`PCS_CTRL_W-1:0]  xgmii_ctrl_i,
	// upstream must hold its word while this is high
	output logic                                am_stall_o,
	output logic [`PCS_LANE_N*`PCS_HEAD_W-1:0]  head_o,
	output logic [`PCS_LANE_N*`PCS_DATA_W-1:0]  data_o
);

	logic                                advance;
	logic                                marker_v;
	logic [`PCS_LANE_N*`PCS_HEAD_W-1:0]  enc_head;
	logic [`PCS_LANE_N*`PCS_DATA_W-1:0]  scr_data;

	// encoders and scramblers only move on consumed words
	// during a marker beat they hold the block the marker displaced
	assign advance = tx_valid_i & ~marker_v;

	for (genvar i = 0; i < `PCS_LANE_N; i++) begin : gen_lane
		pcs_pkg::block_head_t    head_lane;
		pcs_pkg::block_payload_u payload_lane;
		logic [`PCS_DATA_W-1:0]  scr_lane;

		pcs_encoder m_encoder (
			.clk         (clk),
			.nreset      (nreset),
			.advance_i   (advance),
			.xgmii_data_i(xgmii_data_i[i*`PCS_DATA_W +: `PCS_DATA_W]),
			.xgmii_ctrl_i(xgmii_ctrl_i[i*`PCS_CTRL_W +: `PCS_CTRL_W]),
			.head_o      (head_lane),
			.payload_o   (payload_lane)
		);

		// header bypasses the scrambler
		pcs_scrambler m_scrambler (
			.clk       (clk),
			.nreset    (nreset),
			.advance_i (advance),
			.payload_i (payload_lane),
			.payload_o (scr_lane)
		);

		assign enc_head[i*`PCS_HEAD_W +: `PCS_HEAD_W] = head_lane;
		assign scr_data[i*`PCS_DATA_W +: `PCS_DATA_W] = scr_lane;
	end

	// marker insertion and output register for all lanes
	am_tx m_am_tx (
		.clk       (clk),
		.nreset    (nreset),
		.valid_i   (tx_valid_i),
		.head_i    (enc_head),
		.data_i    (scr_data),
		.head_o    (head_o),
		.data_o    (data_o),
		.marker_v_o(marker_v)
	);

	assign am_stall_o = marker_v;

endmodule

/* run_sim.sh */
#!/bin/sh
# builds the PCS transmit testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
	-f filelist.f --top-module pcs_tx_tb -o pcs_tx_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/pcs_tx_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation ended with status $status"
	exit $status
fi

echo "simulation finished cleanly"
exit 0

/* tests/pcs_tx_tb.sv */
// PCS transmit testbench
`timescale 1ns/100ps
`include "pcs_settings.svh"

module pcs_tx_tb;

	localparam int LANES = `PCS_LANE_N;
	localparam int DATA_W = `PCS_DATA_W;
	localparam int CTRL_W = `PCS_CTRL_W;
	localparam int HEAD_W = `PCS_HEAD_W;
	localparam int BLK_W = HEAD_W + DATA_W;
	localparam int GAP_MAX = (1 << `PCS_AM_GAP_W) - 1;
	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 10;
	// two markers fall before the mid-run reset and a short run follows it
	localparam int PHASE1_BEATS = 33000;
	localparam int PHASE2_BEATS = 3000;
	// valid is high well above half the time, so two cycles per beat is the worst case
	localparam int WATCHDOG_BEATS = 40000;
	localparam int WATCHDOG_NS = (WATCHDOG_BEATS * 2 + 2 * RESET_CYCLES + 1000) * CLK_PERIOD;

	logic                       clk;
	logic                       nreset;
	logic                       tx_valid_i;
	logic [LANES*DATA_W-1:0]    xgmii_data_i;
	logic [LANES*CTRL_W-1:0]    xgmii_ctrl_i;
	logic                       am_stall_o;
	logic [LANES*HEAD_W-1:0]    head_o;
	logic [LANES*DATA_W-1:0]    data_o;

	// the reference model keeps one scrambler and one BIP accumulator per lane
	logic [57:0]                scr_state [LANES];
	logic [7:0]                 bip_acc [LANES];
	// each entry holds all lanes of one beat waiting in the encoder stage
	logic [LANES*BLK_W-1:0]     pend_q [$];
	logic [LANES*HEAD_W-1:0]    exp_head;
	logic [LANES*DATA_W-1:0]    exp_data;
	logic                       exp_stall;
	logic                       exp_check;
	int                         beat_n;
	bit                         model_ready = 1'b0;
	int                         marker_n = 0;
	int                         data_n = 0;
	int                         idle_n = 0;
	int                         error_n = 0;

	pcs_tx_top dut_i (
		.clk         (clk),
		.nreset      (nreset),
		.tx_valid_i  (tx_valid_i),
		.xgmii_data_i(xgmii_data_i),
		.xgmii_ctrl_i(xgmii_ctrl_i),
		.am_stall_o  (am_stall_o),
		.head_o      (head_o),
		.data_o      (data_o)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped on the first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual) begin
			stop_with_failure($sformatf("FAIL %s: expected %h, actual %h", name, expected,
				actual));
		end
	endtask

	// 64b/66b encoding with the header in the two low bits of the block
	function automatic logic [BLK_W-1:0] encode_ref(input logic [63:0] d, input logic [7:0] c);
		logic [6:0] code;
		if (c == 8'h00) begin
			return {d, 2'b01};
		end
		// a clean idle word gets idle codes and everything else gets error codes
		code = (c == 8'hff && d == {8{8'h07}}) ? 7'h00 : 7'h1e;
		return {{8{code}}, 8'h1e, 2'b10};
	endfunction

	// scrambles with x^58 + x^39 + 1 and returns the new state above the scrambled payload
	function automatic logic [121:0] scramble_ref(input logic [63:0] din, input logic [57:0] st);
		logic [63:0] dout;
		logic [57:0] s;
		s = st;
		for (int i = 0; i < 64; i++) begin
			dout[i] = din[i] ^ s[38] ^ s[57];
			s = {s[56:0], dout[i]};
		end
		return {s, dout};
	endfunction

	// bit k collects every block bit whose index is k mod 8
	function automatic logic [7:0] bip_ref(input logic [BLK_W-1:0] blk);
		logic [7:0] p;
		p = 8'h00;
		for (int k = 0; k < 8; k++) begin
			for (int i = k; i < BLK_W; i += 8) begin
				p[k] ^= blk[i];
			end
		end
		return p;
	endfunction

	function automatic logic [BLK_W-1:0] marker_ref(input int lane, input logic [7:0] bip);
		logic [63:0] m;
		case (lane)
			0: m = `PCS_AM_LANE0;
			1: m = `PCS_AM_LANE1;
			2: m = `PCS_AM_LANE2;
			default: m = `PCS_AM_LANE3;
		endcase
		m[31:24] = bip;
		m[63:56] = ~bip;
		return {m, 2'b10};
	endfunction

	// words are mostly data with some idle, mixed control and corrupted idle words
	function automatic logic [71:0] random_word();
		int kind;
		int pos;
		logic [31:0] r0;
		logic [31:0] r1;
		logic [63:0] d;
		logic [7:0] c;
		kind = $urandom_range(9, 0);
		r0 = $urandom();
		r1 = $urandom();
		d = {r0, r1};
		c = 8'h00;
		if (kind >= 6 && kind < 8) begin
			c = 8'hff;
			d = {8{8'h07}};
		end else if (kind == 8) begin
			c = r0[7:0];
			if (c == 8'h00 || c == 8'hff) begin
				c = 8'h5a;
			end
		end else if (kind == 9) begin
			c = 8'hff;
			d = {8{8'h07}};
			pos = int'(r1[2:0]);
			d[pos*8 +: 8] = 8'hfe;
		end
		return {c, d};
	endfunction

	task automatic load_word();
		logic [71:0] w;
		for (int l = 0; l < LANES; l++) begin
			w = random_word();
			xgmii_data_i[l*DATA_W +: DATA_W] = w[63:0];
			xgmii_ctrl_i[l*CTRL_W +: CTRL_W] = w[71:64];
		end
	endtask

	// reset is released 1 ns after the tenth rising edge
	task automatic apply_reset();
		nreset = 1'b1;
		tx_valid_i = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		nreset = 1'b0;
	endtask

	// a held word stays on the inputs until a beat without stall takes it
	task automatic run_beats(input int n);
		int done;
		logic consumed;
		done = 0;
		load_word();
		while (done < n) begin
			tx_valid_i = ($urandom_range(99, 0) < 80);
			consumed = tx_valid_i & ~am_stall_o;
			if (tx_valid_i) begin
				done++;
			end
			@(posedge clk);
			#1;
			if (consumed) begin
				load_word();
			end
		end
	endtask

	task automatic reset_model();
		logic [LANES*BLK_W-1:0] entry;
		logic [121:0] sr;
		pend_q.delete();
		for (int l = 0; l < LANES; l++) begin
			scr_state[l] = '1;
			bip_acc[l] = 8'h00;
			// the cleared encoder register is the first block through the scrambler
			sr = scramble_ref(64'h0, scr_state[l]);
			scr_state[l] = sr[121:64];
			entry[l*BLK_W +: BLK_W] = {sr[63:0], 2'b00};
		end
		pend_q.push_back(entry);
		exp_head = '0;
		exp_data = '0;
		exp_stall = 1'b0;
		exp_check = 1'b1;
		beat_n = 0;
		model_ready = 1'b1;
	endtask

	// one beat carries either a marker on every lane or the oldest held block
	task automatic step_beat();
		logic [LANES*BLK_W-1:0] cur;
		logic [LANES*BLK_W-1:0] nxt;
		logic [BLK_W-1:0] blk;
		logic [121:0] sr;
		if (exp_stall) begin
			for (int l = 0; l < LANES; l++) begin
				blk = marker_ref(l, bip_acc[l]);
				bip_acc[l] = bip_ref(blk);
				exp_head[l*HEAD_W +: HEAD_W] = blk[1:0];
				exp_data[l*DATA_W +: DATA_W] = blk[BLK_W-1:2];
			end
			marker_n++;
			exp_check = 1'b1;
		end else begin
			cur = pend_q.pop_front();
			for (int l = 0; l < LANES; l++) begin
				blk = cur[l*BLK_W +: BLK_W];
				bip_acc[l] ^= bip_ref(blk);
				exp_head[l*HEAD_W +: HEAD_W] = blk[1:0];
				exp_data[l*DATA_W +: DATA_W] = blk[BLK_W-1:2];
			end
			// the block right after reset is the cleared encoder content
			exp_check = (beat_n != 0);
			for (int l = 0; l < LANES; l++) begin
				blk = encode_ref(xgmii_data_i[l*DATA_W +: DATA_W],
					xgmii_ctrl_i[l*CTRL_W +: CTRL_W]);
				if (blk[1:0] == 2'b01) begin
					data_n++;
				end else if (blk[BLK_W-1:2] == 64'h1e) begin
					idle_n++;
				end else begin
					error_n++;
				end
				sr = scramble_ref(blk[BLK_W-1:2], scr_state[l]);
				scr_state[l] = sr[121:64];
				nxt[l*BLK_W +: BLK_W] = {sr[63:0], blk[1:0]};
			end
			pend_q.push_back(nxt);
		end
		// the stall falls on beat 16383 after reset and then on every 16384th beat
		exp_stall = (((beat_n + 1) % (GAP_MAX + 1)) == GAP_MAX);
		beat_n++;
	endtask

	// inputs and outputs are all stable at the falling edge
	always @(negedge clk) begin
		if (model_ready) begin
			check_value("am_stall_o", 64'(exp_stall), 64'(am_stall_o));
			if (exp_check) begin
				for (int l = 0; l < LANES; l++) begin
					check_value($sformatf("lane %0d head", l),
						64'(exp_head[l*HEAD_W +: HEAD_W]), 64'(head_o[l*HEAD_W +: HEAD_W]));
					check_value($sformatf("lane %0d data", l),
						exp_data[l*DATA_W +: DATA_W], data_o[l*DATA_W +: DATA_W]);
				end
			end
		end
		if (nreset) begin
			reset_model();
		end else if (model_ready && tx_valid_i) begin
			step_beat();
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		stop_with_failure("timeout, the run did not finish in the allowed time");
	end

	initial begin : stimulus
		void'($urandom(32'hedfb));
		nreset = 1'b1;
		tx_valid_i = 1'b0;
		xgmii_data_i = '0;
		xgmii_ctrl_i = '0;
		apply_reset();
		run_beats(PHASE1_BEATS);
		// a second reset in the middle makes the scramblers restart from all ones
		apply_reset();
		run_beats(PHASE2_BEATS);
		tx_valid_i = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		if (marker_n < 2) begin
			stop_with_failure("fewer than two marker beats were checked");
		end else if (data_n == 0 || idle_n == 0 || error_n == 0) begin
			stop_with_failure("data, idle or error blocks were never exercised");
		end else begin
			$display("ALL TESTS PASSED");
			$finish;
		end
	end

endmodule
